//--- stim_driver.f
source/stim_pkg.sv
source/stim_ram.sv
source/stim_playback.sv
source/stim_lfsr.sv
source/stim_select.sv
source/stim_driver.sv
verif/tb_clock.sv
verif/stim_driver_asserts.sv
verif/tb_stim_driver.sv

//--- Makefile
# Verilator build and run of the stim_driver testbench

VERILATOR ?= verilator
TOP       ?= tb_stim_driver
DUT_TOP   ?= stim_driver
FILELIST  ?= stim_driver.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SIM_BIN  = $(BUILD_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_stim_driver.sv
module tb_stim_driver;

   logic                    dut_clk;
   logic                    nreset;
   stim_pkg::stim_mode_e    mode;
   logic [stim_pkg::pw-1:0] seed;
   logic                    ext_valid;
   logic [stim_pkg::pw-1:0] ext_packet;
   logic                    dut_ready;
   logic                    stim_valid;
   logic [stim_pkg::pw-1:0] stim_packet;
   logic                    stim_done;

   int seed_var;                    // $random state
   int value_errors;
   int other_errors;
   int assert_fails;
   int cycles;
   int cycle_limit;
   int play_limit = 500;            // Cycles allowed per playback run
   int ready_cnt;                   // Ready-high cycles since last play beat
   int rng_beats;
   int rng_ready;
   logic [31:0] rng_seed;
   logic [31:0] lfsr_model;

   // Inputs of the cycle whose result shows at the next negedge
   stim_pkg::stim_mode_e prev_mode;
   logic                 prev_ready;
   logic                 prev_valid;
   logic [31:0]          prev_packet;
   logic [31:0]          prev_seed;

   logic [31:0] exp_words[$];
   int          exp_delays[$];
   logic [31:0] got_words[$];
   int          got_gaps[$];

   tb_clock u_tb_clock (.dut_clk (dut_clk));

   stim_driver u_stim_driver
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .mode        (mode),
      .seed        (seed),
      .ext_valid   (ext_valid),
      .ext_packet  (ext_packet),
      .dut_ready   (dut_ready),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done)
   );

   //##############################
   // Checking helpers
   //##############################

   task automatic compare_bit(input string sig, input logic exp, input logic got);
      assert (got === exp)
      else
      begin
         value_errors++;
         $display("[FAIL] %0t %s expected %0b got %0b", $time, sig, exp, got);
      end
   endtask

   task automatic compare_word(input string sig, input logic [31:0] exp,
                               input logic [31:0] got);
      assert (got === exp)
      else
      begin
         value_errors++;
         $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, got);
      end
   endtask

   task automatic compare_count(input string sig, input int exp, input int got);
      assert (got == exp)
      else
      begin
         value_errors++;
         $display("[FAIL] %0t %s expected %0d got %0d", $time, sig, exp, got);
      end
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("ERROR at time %0t: %s", $time, msg);
   endtask

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $random(seed_var);
      return r[0];
   endfunction

   // Shift left, bit 0 from taps 31, 21, 1 and 0
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int worst_case_cycles();
      int load_len;
      int play_len;
      load_len = 13;                   // Pointer clear, ten words, terminator, idle
      play_len = play_limit + 8;       // Plus done hold and exit
      return 16 + 6 + 2 * load_len + 3 * play_len + 62 + 31 + 100;
   endfunction

   // Outputs at this negedge belong to the cycle driven with prev_*
   task automatic observe();
      if (prev_mode != stim_pkg::mode_play)
         compare_bit("stim_done", 1'b0, stim_done);
      case (prev_mode)
         stim_pkg::mode_load:
         begin
            compare_bit("stim_valid", 1'b0, stim_valid);
            compare_word("stim_packet", '0, stim_packet);
         end
         stim_pkg::mode_bypass:
         begin
            compare_bit("stim_valid", prev_valid, stim_valid);
            if (prev_valid)
               compare_word("stim_packet", prev_packet, stim_packet);
         end
         stim_pkg::mode_rng:
         begin
            compare_bit("stim_valid", prev_ready, stim_valid);
            if (prev_ready)
            begin
               lfsr_model = lfsr_next(lfsr_model);
               rng_ready++;
               compare_word("stim_packet", lfsr_model, stim_packet);
            end
            if (stim_valid)
               rng_beats++;
         end
         default:
         begin
            if (prev_ready)
               ready_cnt++;
            if (stim_valid)
            begin
               assert (prev_ready)
               else
                  report_problem("play beat issued while dut_ready was low");
               got_words.push_back(stim_packet);
               got_gaps.push_back(ready_cnt);
               ready_cnt = 0;
            end
         end
      endcase
      if (prev_mode != stim_pkg::mode_rng)
         lfsr_model = prev_seed;        // DUT reseeds here
      if (prev_mode != stim_pkg::mode_play)
         ready_cnt = 0;
      prev_mode   = mode;
      prev_ready  = dut_ready;
      prev_valid  = ext_valid;
      prev_packet = ext_packet;
      prev_seed   = seed;
   endtask

   // One clock of stimulus, then check what came out
   task automatic run_cycle(input stim_pkg::stim_mode_e m, input logic rdy,
                            input logic ev, input logic [31:0] ep);
      @(posedge dut_clk);
      mode       <= m;
      dut_ready  <= rdy;
      ext_valid  <= ev;
      ext_packet <= ep;
      seed       <= rng_seed;
      @(negedge dut_clk);
      observe();
   endtask

   //##############################
   // Playback helpers
   //##############################

   task automatic load_words(input int count, input int max_delay);
      logic [31:0] r;
      logic [31:0] word;
      logic [6:0]  dly;
      int          d;
      exp_words.delete();
      exp_delays.delete();
      run_cycle(stim_pkg::mode_bypass, 1'b1, 1'b0, '0);   // Write pointer back to 0
      for (int i = 0; i < count; i++)
      begin
         r    = $random(seed_var);
         d    = int'(r[30:24]) % (max_delay + 1);
         dly  = 7'(d);
         word = {r[23:0], dly, 1'b1};   // Payload, delay, valid
         exp_words.push_back(word);
         exp_delays.push_back(d);
         run_cycle(stim_pkg::mode_load, 1'b1, 1'b1, word);
      end
      r = $random(seed_var);
      run_cycle(stim_pkg::mode_load, 1'b1, 1'b1, {r[31:1], 1'b0});   // Terminator
      run_cycle(stim_pkg::mode_load, 1'b1, 1'b0, '0);
   endtask

   task automatic check_play_results();
      int n;
      assert (got_words.size() == exp_words.size())
      else
         report_problem($sformatf("play gave %0d beats instead of %0d",
                                  got_words.size(), exp_words.size()));
      n = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
      for (int i = 0; i < n; i++)
         compare_word($sformatf("stim_packet[%0d]", i), exp_words[i], got_words[i]);
      // Gap before beat i is set by the delay of beat i-1
      for (int i = 1; i < n; i++)
         compare_count($sformatf("beat gap[%0d]", i), exp_delays[i-1] + 1, got_gaps[i]);
   endtask

   task automatic play_sequence(input logic random_ready);
      int   n;
      logic rdy;
      got_words.delete();
      got_gaps.delete();
      n = 0;
      while (!stim_done && n < play_limit)
      begin
         rdy = random_ready ? rand_bit() : 1'b1;
         run_cycle(stim_pkg::mode_play, rdy, 1'b0, '0);
         n++;
      end
      assert (stim_done)
      else
         report_problem("stim_done never rose during playback");
      repeat (6)                       // Done holds, nothing more comes out
      begin
         run_cycle(stim_pkg::mode_play, rand_bit(), 1'b0, '0);
         compare_bit("stim_done", 1'b1, stim_done);
      end
      repeat (2)
         run_cycle(stim_pkg::mode_load, 1'b1, 1'b0, '0);
      check_play_results();
   endtask

   //##############################
   // Directed tests
   //##############################

   task automatic outputs_after_reset();
      compare_bit("stim_valid", 1'b0, stim_valid);
      compare_bit("stim_done", 1'b0, stim_done);
      compare_word("stim_packet", '0, stim_packet);
      repeat (4)
         run_cycle(stim_pkg::mode_load, 1'b1, rand_bit(), $random(seed_var));
   endtask

   task automatic load_and_play();
      load_words(10, 3);
      play_sequence(1'b0);
   endtask

   task automatic delay_pacing();
      load_words(10, 9);               // Longer pauses
      play_sequence(1'b0);
   endtask

   // Replays the memory of the previous test
   task automatic back_pressure();
      play_sequence(1'b1);
   endtask

   task automatic random_mode();
      logic [31:0] r;
      r = $random(seed_var);
      if (r == '0)
         r = 32'd1;                    // LFSR needs a nonzero seed
      rng_seed = r;
      run_cycle(stim_pkg::mode_load, 1'b1, 1'b0, '0);
      rng_beats = 0;
      rng_ready = 0;
      repeat (60)
         run_cycle(stim_pkg::mode_rng, rand_bit(), 1'b0, '0);
      run_cycle(stim_pkg::mode_load, 1'b1, 1'b0, '0);
      compare_count("rng beat count", rng_ready, rng_beats);
   endtask

   task automatic bypass_mode();
      repeat (30)
         run_cycle(stim_pkg::mode_bypass, rand_bit(), rand_bit(), $random(seed_var));
      run_cycle(stim_pkg::mode_load, 1'b1, 1'b0, '0);
   endtask

   //##############################
   // Run control
   //##############################

   always @(posedge dut_clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: run exceeded %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      seed_var     = 6;
      value_errors = 0;
      other_errors = 0;
      cycles       = 0;
      ready_cnt    = 0;
      rng_seed     = 32'd1;
      lfsr_model   = 32'd1;
      nreset       = 1'b0;
      mode         = stim_pkg::mode_load;
      seed         = 32'd1;
      ext_valid    = 1'b0;
      ext_packet   = '0;
      dut_ready    = 1'b0;
      prev_mode    = stim_pkg::mode_load;
      prev_ready   = 1'b0;
      prev_valid   = 1'b0;
      prev_packet  = '0;
      prev_seed    = 32'd1;
      cycle_limit  = worst_case_cycles();
      repeat (16) @(posedge dut_clk);
      nreset <= 1'b1;
      @(negedge dut_clk);
      outputs_after_reset();
      load_and_play();
      delay_pacing();
      back_pressure();
      random_mode();
      bypass_mode();
      assert_fails = u_stim_driver.u_stim_driver_asserts.fail_count;
      $display("Error counts: %0d wrong values, %0d other failures, %0d assertion failures",
               value_errors, other_errors, assert_fails);
      if (value_errors + other_errors + assert_fails == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- verif/stim_driver_asserts.sv
module stim_driver_asserts
(
   input logic                    dut_clk,
   input logic                    nreset,
   input stim_pkg::stim_mode_e    mode,
   input logic                    stim_valid,
   input logic [stim_pkg::pw-1:0] stim_packet,
   input logic                    stim_done
);

   int fail_count = 0;   // Failed assertion count, read by the testbench

   // Beat and done never share a cycle
   valid_done_excl: assert property (@(posedge dut_clk) disable iff (!nreset)
      !(stim_valid && stim_done))
   else
   begin
      fail_count = fail_count + 1;
      $error("stim_valid and stim_done high in the same cycle");
   end

   // Loading keeps the output quiet one cycle later
   quiet_after_load: assert property (@(posedge dut_clk) disable iff (!nreset)
      (mode == stim_pkg::mode_load) |=> !stim_valid)
   else
   begin
      fail_count = fail_count + 1;
      $error("stim_valid high in the cycle after a load cycle");
   end

   // No X on outputs out of reset
   outputs_known: assert property (@(posedge dut_clk) disable iff (!nreset)
      !$isunknown({stim_valid, stim_done, stim_packet}))
   else
   begin
      fail_count = fail_count + 1;
      $error("unknown value on a stim_driver output");
   end

endmodule

bind stim_driver stim_driver_asserts u_stim_driver_asserts
(
   .dut_clk     (dut_clk),
   .nreset      (nreset),
   .mode        (mode),
   .stim_valid  (stim_valid),
   .stim_packet (stim_packet),
   .stim_done   (stim_done)
);

//--- verif/tb_clock.sv
module tb_clock
(
   output logic dut_clk
);

   // Period 40, starts low
   initial
   begin
      dut_clk = 1'b0;
      forever #20 dut_clk = ~dut_clk;
   end

endmodule

//--- source/stim_driver.sv
module stim_driver
(
   input  logic                    dut_clk,
   input  logic                    nreset,
   input  stim_pkg::stim_mode_e    mode,
   input  logic [stim_pkg::pw-1:0] seed,         // LFSR start value
   // Host side
   input  logic                    ext_valid,
   input  logic [stim_pkg::pw-1:0] ext_packet,
   // DUT side
   input  logic                    dut_ready,
   output logic                    stim_valid,
   output logic [stim_pkg::pw-1:0] stim_packet,
   output logic                    stim_done
);

   stim_pkg::stim_beat_t play_beat;   // From memory playback
   stim_pkg::stim_beat_t rng_beat;    // From LFSR
   logic                 play_done;

   //##############################
   // Producers
   //##############################

   stim_playback u_stim_playback
   (
      .dut_clk    (dut_clk),
      .nreset     (nreset),
      .mode       (mode),
      .ext_valid  (ext_valid),
      .ext_packet (ext_packet),
      .dut_ready  (dut_ready),
      .play_beat  (play_beat),
      .play_done  (play_done)
   );

   stim_lfsr u_stim_lfsr
   (
      .dut_clk   (dut_clk),
      .nreset    (nreset),
      .mode      (mode),
      .seed      (seed),
      .dut_ready (dut_ready),
      .rng_beat  (rng_beat)
   );

   // Output stage
   stim_select u_stim_select
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .mode        (mode),
      .play_beat   (play_beat),
      .rng_beat    (rng_beat),
      .ext_valid   (ext_valid),
      .ext_packet  (ext_packet),
      .play_done   (play_done),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done)
   );

endmodule

//--- source/stim_select.sv
module stim_select
(
   input  logic                    dut_clk,
   input  logic                    nreset,
   input  stim_pkg::stim_mode_e    mode,
   input  stim_pkg::stim_beat_t    play_beat,
   input  stim_pkg::stim_beat_t    rng_beat,
   input  logic                    ext_valid,
   input  logic [stim_pkg::pw-1:0] ext_packet,
   input  logic                    play_done,
   output logic                    stim_valid,
   output logic [stim_pkg::pw-1:0] stim_packet,
   output logic                    stim_done
);

   stim_pkg::stim_beat_t sel_beat;    // Chosen beat this cycle
   stim_pkg::stim_beat_t out_beat;    // Registered output beat
   logic                 done_q;

   //##############################
   // Mode mux
   //##############################

   always_comb
   begin
      unique case (mode)
         stim_pkg::mode_play:   sel_beat = play_beat;
         stim_pkg::mode_rng:    sel_beat = rng_beat;
         stim_pkg::mode_bypass: sel_beat = '{valid: ext_valid, packet: ext_packet};
         default:               sel_beat = '0;        // Quiet while loading
      endcase
   end

   //##############################
   // Output register
   //##############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         out_beat <= '0;
         done_q   <= 1'b0;
      end
      else
      begin
         out_beat <= sel_beat;
         done_q   <= play_done;      // Same lag as the beats
      end
   end

   assign stim_valid  = out_beat.valid;
   assign stim_packet = out_beat.packet;
   assign stim_done   = done_q;

endmodule

//--- source/stim_lfsr.sv
module stim_lfsr
(
   input  logic                    dut_clk,
   input  logic                    nreset,
   input  stim_pkg::stim_mode_e    mode,
   input  logic [stim_pkg::pw-1:0] seed,       // Must be nonzero
   input  logic                    dut_ready,
   output stim_pkg::stim_beat_t    rng_beat
);

   logic [stim_pkg::pw-1:0] lfsr;
   logic [stim_pkg::pw-1:0] lfsr_nxt;
   logic                    step;

   // Advance only when running and DUT accepts
   assign step = (mode == stim_pkg::mode_rng) & dut_ready;

   // Shift left, XOR of tapped bits enters at bit 0
   assign lfsr_nxt = {lfsr[stim_pkg::pw-2:0], ^(lfsr & stim_pkg::lfsr_taps)};

   //##############################
   // State register
   //##############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         lfsr <= '1;                      // Any nonzero state
      else if (mode != stim_pkg::mode_rng)
         lfsr <= seed;                    // Reseed outside random mode
      else if (dut_ready)
         lfsr <= lfsr_nxt;
   end

   // One beat per step, new state as packet
   assign rng_beat.valid  = step;
   assign rng_beat.packet = lfsr_nxt;

endmodule

//--- source/stim_playback.sv
module stim_playback
(
   input  logic                    dut_clk,
   input  logic                    nreset,
   input  stim_pkg::stim_mode_e    mode,
   input  logic                    ext_valid,    // Host write strobe
   input  logic [stim_pkg::pw-1:0] ext_packet,
   input  logic                    dut_ready,
   output stim_pkg::stim_beat_t    play_beat,
   output logic                    play_done
);

   typedef enum logic [2:0]
   {
      st_idle,     // Waiting for play mode
      st_fetch,    // First read in flight
      st_active,   // Word at rd_addr on the RAM output
      st_pause,    // Counting out the delay field
      st_done      // Terminator reached
   } seq_state_e;

   seq_state_e                 state;
   seq_state_e                 state_nxt;
   logic [stim_pkg::maw-1:0]   wr_ptr;      // Load pointer
   logic [stim_pkg::maw-1:0]   rd_addr;     // Address of word on rd_word
   logic [stim_pkg::maw-1:0]   addr_nxt;
   logic [stim_pkg::cw-2:0]    wait_cnt;    // Ready cycles left in pause
   logic [stim_pkg::cw-2:0]    cnt_nxt;
   logic                       rd_pend;     // RAM output holds rd_addr word
   logic                       pend_nxt;
   logic                       in_play;
   logic                       in_load;
   logic                       take;        // Current word consumed
   stim_pkg::stim_word_u       rd_word;

   assign in_play = (mode == stim_pkg::mode_play);
   assign in_load = (mode == stim_pkg::mode_load);

   //##############################
   // Load side
   //##############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         wr_ptr <= '0;
      else if (!in_load)
         wr_ptr <= '0;                    // Every load starts at word 0
      else if (ext_valid)
         wr_ptr <= wr_ptr + 1'b1;
   end

   stim_ram u_stim_ram
   (
      .dut_clk (dut_clk),
      .wr_en   (in_load & ext_valid),
      .wr_addr (wr_ptr),
      .wr_data (ext_packet),
      .rd_addr (addr_nxt),                // Lines RAM output up with rd_addr
      .rd_data (rd_word)
   );

   //##############################
   // Sequencer
   //##############################

   // Ready freezes everything, terminator included
   assign take = in_play & (state == st_active) & rd_pend & dut_ready;

   always_comb
   begin
      state_nxt = state;
      addr_nxt  = rd_addr;                // Default re-reads same word
      cnt_nxt   = wait_cnt;
      pend_nxt  = rd_pend;
      if (!in_play)
      begin
         state_nxt = st_idle;             // Leaving play rewinds
         addr_nxt  = '0;
         cnt_nxt   = '0;
         pend_nxt  = 1'b0;
      end
      else
      begin
         unique case (state)
            st_idle:
               state_nxt = st_fetch;
            st_fetch:
            begin
               pend_nxt  = 1'b1;          // Word 0 read this cycle
               state_nxt = st_active;
            end
            st_active:
            begin
               if (take)
               begin
                  if (!rd_word.fields.valid)
                     state_nxt = st_done;   // End marker, no beat
                  else
                  begin
                     addr_nxt = rd_addr + 1'b1;   // Prefetch next word
                     if (rd_word.fields.delay != '0)
                     begin
                        cnt_nxt   = rd_word.fields.delay;
                        state_nxt = st_pause;
                     end
                  end
               end
            end
            st_pause:
            begin
               if (dut_ready)
               begin
                  cnt_nxt = wait_cnt - 1'b1;
                  if (cnt_nxt == '0)
                     state_nxt = st_active;
               end
            end
            st_done:
               pend_nxt = 1'b0;           // Hold until mode changes
            default:
               state_nxt = st_idle;
         endcase
      end
   end

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state    <= st_idle;
         rd_addr  <= '0;
         wait_cnt <= '0;
         rd_pend  <= 1'b0;
      end
      else
      begin
         state    <= state_nxt;
         rd_addr  <= addr_nxt;
         wait_cnt <= cnt_nxt;
         rd_pend  <= pend_nxt;
      end
   end

   // Beat is the whole raw word
   assign play_beat.valid  = take & rd_word.fields.valid;
   assign play_beat.packet = rd_word.raw;
   assign play_done        = in_play & (state == st_done);

endmodule

//--- source/stim_ram.sv
module stim_ram
(
   input  logic                     dut_clk,
   // Write side, host load
   input  logic                     wr_en,
   input  logic [stim_pkg::maw-1:0] wr_addr,
   input  logic [stim_pkg::pw-1:0]  wr_data,
   // Read side, sequencer
   input  logic [stim_pkg::maw-1:0] rd_addr,
   output stim_pkg::stim_word_u     rd_data
);

   // Storage array
   logic [stim_pkg::pw-1:0] mem [stim_pkg::depth];

   //##############################
   // Write port
   //##############################

   always_ff @(posedge dut_clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   //##############################
   // Read port
   //##############################

   // Read every cycle, data one cycle behind the address
   always_ff @(posedge dut_clk)
   begin
      rd_data.raw <= mem[rd_addr];
   end

endmodule

//--- source/stim_pkg.sv
package stim_pkg;

   //##############################
   // Sizes
   //##############################

   localparam int pw    = 32;             // Packet width
   localparam int cw    = 8;              // Control byte, valid plus delay
   localparam int depth = 64;             // Stimulus words
   localparam int maw   = $clog2(depth);  // Memory address width

   // Fibonacci feedback from bits 31, 21, 1 and 0
   localparam logic [pw-1:0] lfsr_taps = 32'h8020_0003;

   //##############################
   // Types
   //##############################

   typedef enum logic [1:0]
   {
      mode_load   = 2'd0,   // Host fills memory
      mode_play   = 2'd1,   // Paced playback
      mode_rng    = 2'd2,   // LFSR packets
      mode_bypass = 2'd3    // Host straight through
   } stim_mode_e;

   // One memory word, seen whole or split into fields
   typedef union packed
   {
      logic [pw-1:0] raw;             // As stored and driven out
      struct packed
      {
         logic [pw-cw-1:0] payload;   // 24 bit payload
         logic [cw-2:0]    delay;     // Ready cycles after the beat
         logic             valid;     // Clear marks end of sequence
      } fields;
   } stim_word_u;

   // Result of one producer for one cycle
   typedef struct packed
   {
      logic          valid;
      logic [pw-1:0] packet;
   } stim_beat_t;

endpackage
